/* design/fei4_rx_reg_pkg.sv */
// register map and bus widths of the FE-I4 receiver
// shared by the address decoder, the register file and the local bus interface
package fei4_rx_reg_pkg;

    localparam int ABUSWIDTH = 16; // system bus address
    localparam int IP_AW     = 4;  // address inside the window

    // local register addresses
    localparam logic [IP_AW-1:0] REG_RESET    = 4'd0; // write: soft reset, read: version
    localparam logic [IP_AW-1:0] REG_RX_RESET = 4'd1; // write: receiver only reset
    localparam logic [IP_AW-1:0] REG_STATUS   = 4'd2;
    localparam logic [IP_AW-1:0] REG_SIZE_LO  = 4'd3; // latches the high byte
    localparam logic [IP_AW-1:0] REG_SIZE_HI  = 4'd4;
    localparam logic [IP_AW-1:0] REG_DEC_ERR  = 4'd5;
    localparam logic [IP_AW-1:0] REG_LOST_ERR = 4'd6;

    localparam logic [7:0] VERSION = 8'd2;

    // status register bit that inverts the serial input
    localparam int STATUS_INVERT_BIT = 1;

endpackage

/* design/fei4_rx_link_pkg.sv */
// 8b10b link constants, sync and framing state types of the FE-I4 receiver
// imported by the receiver chain and the readout FIFO
package fei4_rx_link_pkg;

    // decoded control bytes
    localparam logic [7:0] K_COMMA = 8'hBC; // K28.5
    localparam logic [7:0] K_SOF   = 8'hFC; // K28.7
    localparam logic [7:0] K_EOF   = 8'h7C; // K28.3

    // bits abcdeif of K28.5, the two forms of the comma
    localparam logic [6:0] COMMA_POS = 7'b0011111;
    localparam logic [6:0] COMMA_NEG = 7'b1100000;

    localparam int SYNC_COMMAS = 4; // aligned commas before lock

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = 4;

    typedef enum logic [1:0] {
        HUNT,   // searching every bit position
        CHECK,  // phase fixed, counting commas
        LOCKED
    } sync_state_t;

    typedef enum logic [1:0] {
        IDLE,   // outside a frame
        BYTE0,  // SOF seen, waiting for the first byte
        BYTE1,
        BYTE2
    } frame_state_t;

endpackage

/* design/fei4_rx_ifs.sv */
// interfaces inside the receiver: local register bus and decoded symbol stream
// ip_bus_if joins the address decoder and the core, rx_symbol_if the decoder and framer
`timescale 1ns/1ps

interface ip_bus_if;
    import fei4_rx_reg_pkg::*;

    logic [IP_AW-1:0] ip_add;  // offset from the window base
    logic [7:0]       ip_data_in;
    logic             ip_wr;
    logic             ip_rd;
    logic [7:0]       ip_data_out;

    modport master (output ip_add, ip_data_in, ip_wr, ip_rd, input ip_data_out);
    modport slave  (input ip_add, ip_data_in, ip_wr, ip_rd, output ip_data_out);
endinterface

interface rx_symbol_if;
    logic       valid;     // one pulse per code group
    logic [7:0] data;
    logic       is_k;
    logic       code_err;

    // no ready, the link cannot be stalled
    modport source (output valid, data, is_k, code_err);
    modport sink   (input valid, data, is_k, code_err);
endinterface

/* design/rx_sync_fifo.sv */
// first-word-fall-through FIFO for received words, with fill level
`timescale 1ns/1ps

module rx_sync_fifo (
    input  logic        BUS_CLK,
    input  logic        reset,
    input  logic        push,
    input  logic [23:0] push_data,
    input  logic        pop,
    output logic [23:0] pop_data,
    output logic        full,
    output logic        empty,
    output logic [15:0] size
);
    import fei4_rx_link_pkg::*;

    logic [23:0]        mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               do_push;
    logic               do_pop;

    assign full     = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign empty    = (count == '0);
    assign size     = {{(15 - FIFO_AW){1'b0}}, count};
    assign do_push  = push && !full;  // dropped when full
    assign do_pop   = pop && !empty;
    assign pop_data = mem[rd_ptr];    // head word, valid while not empty

    always_ff @(posedge BUS_CLK) begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge BUS_CLK) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1; // wraps at FIFO_DEPTH
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

/* design/rx_8b10b_decode.sv */
// 8b10b decoder, either disparity accepted, invalid subblocks flagged and counted
`timescale 1ns/1ps

module rx_8b10b_decode (
    input  logic        BUS_CLK,
    input  logic        reset,
    input  logic        code_valid,
    input  logic [9:0]  code,      // abcdei fghj, a in bit 9
    rx_symbol_if.source sym,
    output logic [7:0]  err_cnt
);

    logic [5:0] six;
    logic [3:0] four;
    logic [4:0] edcba;
    logic [2:0] hgf;
    logic       six_ok;
    logic       four_ok;
    logic       a7;       // alternate x.7 form, also used by K23/27/29/30
    logic       k28;
    logic       bad;

    assign six = code[9:4];
    assign k28 = (six == 6'b001111) || (six == 6'b110000);
    // K28 from positive disparity has its 4b block complemented
    assign four = (six == 6'b110000) ? ~code[3:0] : code[3:0];
    assign bad  = !(six_ok && four_ok);

    always_comb begin
        six_ok = 1'b1;
        case (six)
            6'b100111, 6'b011000: edcba = 5'd0;
            6'b011101, 6'b100010: edcba = 5'd1;
            6'b101101, 6'b010010: edcba = 5'd2;
            6'b110001:            edcba = 5'd3;
            6'b110101, 6'b001010: edcba = 5'd4;
            6'b101001:            edcba = 5'd5;
            6'b011001:            edcba = 5'd6;
            6'b111000, 6'b000111: edcba = 5'd7;
            6'b111001, 6'b000110: edcba = 5'd8;
            6'b100101:            edcba = 5'd9;
            6'b010101:            edcba = 5'd10;
            6'b110100:            edcba = 5'd11;
            6'b001101:            edcba = 5'd12;
            6'b101100:            edcba = 5'd13;
            6'b011100:            edcba = 5'd14;
            6'b010111, 6'b101000: edcba = 5'd15;
            6'b011011, 6'b100100: edcba = 5'd16;
            6'b100011:            edcba = 5'd17;
            6'b010011:            edcba = 5'd18;
            6'b110010:            edcba = 5'd19;
            6'b001011:            edcba = 5'd20;
            6'b101010:            edcba = 5'd21;
            6'b011010:            edcba = 5'd22;
            6'b111010, 6'b000101: edcba = 5'd23;
            6'b110011, 6'b001100: edcba = 5'd24;
            6'b100110:            edcba = 5'd25;
            6'b010110:            edcba = 5'd26;
            6'b110110, 6'b001001: edcba = 5'd27;
            6'b001110, 6'b001111, 6'b110000: edcba = 5'd28; // D28 and K28
            6'b101110, 6'b010001: edcba = 5'd29;
            6'b011110, 6'b100001: edcba = 5'd30;
            6'b101011, 6'b010100: edcba = 5'd31;
            default: begin
                edcba  = 5'd0;
                six_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        four_ok = 1'b1;
        a7      = 1'b0;
        case (four)
            4'b1011, 4'b0100: hgf = 3'd0;
            4'b1001:          hgf = 3'd1;
            4'b0101:          hgf = 3'd2;
            4'b1100, 4'b0011: hgf = 3'd3;
            4'b1101, 4'b0010: hgf = 3'd4;
            4'b1010:          hgf = 3'd5;
            4'b0110:          hgf = 3'd6;
            4'b1110, 4'b0001: hgf = 3'd7;
            4'b0111, 4'b1000: begin
                hgf = 3'd7;
                a7  = 1'b1;
            end
            default: begin
                hgf     = 3'd0;
                four_ok = 1'b0; // 0000 and 1111
            end
        endcase
    end

    always_ff @(posedge BUS_CLK) begin
        if (reset) begin
            sym.valid <= 1'b0;
            err_cnt   <= 8'h00;
        end else begin
            sym.valid <= code_valid;
            if (code_valid && bad && (err_cnt != 8'hFF))
                err_cnt <= err_cnt + 8'd1; // saturates
        end
    end

    always_ff @(posedge BUS_CLK) begin
        sym.data     <= {hgf, edcba};
        sym.is_k     <= k28 || (a7 && (edcba == 5'd23 || edcba == 5'd27 ||
                                       edcba == 5'd29 || edcba == 5'd30));
        sym.code_err <= bad;
    end

endmodule

/* design/rx_frame_builder.sv */
// packs the three data bytes between SOF and EOF into one word for the FIFO
`timescale 1ns/1ps

module rx_frame_builder (
    input  logic        BUS_CLK,
    input  logic        reset,
    rx_symbol_if.sink   sym,
    output logic        push,
    output logic [23:0] push_data,
    input  logic        full,
    output logic [7:0]  lost_cnt
);
    import fei4_rx_link_pkg::*;

    frame_state_t state;
    logic [15:0]  head;      // first two bytes, msb first
    logic         push_req;

    assign push = push_req && !full;

    always_ff @(posedge BUS_CLK) begin
        if (reset) begin
            state    <= IDLE;
            push_req <= 1'b0;
            lost_cnt <= 8'h00;
        end else begin
            push_req <= 1'b0;
            if (push_req && full && (lost_cnt != 8'hFF))
                lost_cnt <= lost_cnt + 8'd1; // word dropped
            if (sym.valid) begin
                if (sym.code_err) begin
                    state <= IDLE;
                end else if (sym.is_k) begin
                    case (sym.data)
                        K_SOF:          state <= BYTE0; // restarts an open frame
                        K_EOF, K_COMMA: state <= IDLE;
                        default:        state <= IDLE;  // unexpected control code
                    endcase
                end else begin
                    case (state)
                        BYTE0:   state <= BYTE1;
                        BYTE1:   state <= BYTE2;
                        BYTE2: begin
                            state    <= IDLE; // further bytes ignored until SOF
                            push_req <= 1'b1;
                        end
                        default: ;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge BUS_CLK) begin
        if (sym.valid && !sym.is_k) begin
            case (state)
                BYTE0:   head[15:8] <= sym.data;
                BYTE1:   head[7:0]  <= sym.data;
                BYTE2:   push_data  <= {head, sym.data};
                default: ;
            endcase
        end
    end

endmodule

/* design/receiver_logic.sv */
// serial front end: comma alignment and sync, feeding decoder, framer and FIFO
`timescale 1ns/1ps

module receiver_logic (
    input  logic        BUS_CLK,
    input  logic        reset,
    input  logic        RX_DATA,
    input  logic        invert_rx_data,
    input  logic        read,
    output logic [23:0] data,
    output logic        empty,
    output logic        full,
    output logic        rec_sync_ready,
    output logic [7:0]  decoder_err_cnt,
    output logic [7:0]  lost_err_cnt,
    output logic [15:0] fifo_size
);
    import fei4_rx_link_pkg::*;

    sync_state_t state;
    logic [9:0]  window;     // bit a ends up in bit 9
    logic [3:0]  bit_cnt;    // position inside the code group
    logic [2:0]  comma_cnt;
    logic        comma_match;
    logic        group_tick;
    logic        code_valid;
    logic        push;
    logic [23:0] push_data;

    always_ff @(posedge BUS_CLK) begin
        window <= {window[8:0], RX_DATA ^ invert_rx_data};
    end

    assign comma_match    = (window[9:3] == COMMA_POS) || (window[9:3] == COMMA_NEG);
    assign group_tick     = (bit_cnt == 4'd9);
    assign code_valid     = group_tick && (state != HUNT);
    assign rec_sync_ready = (state == LOCKED);

    always_ff @(posedge BUS_CLK) begin
        if (reset) begin
            state     <= HUNT;
            bit_cnt   <= 4'd0;
            comma_cnt <= 3'd0;
        end else begin
            bit_cnt <= group_tick ? 4'd0 : bit_cnt + 4'd1;
            case (state)
                HUNT: if (comma_match) begin
                    state     <= CHECK;
                    bit_cnt   <= 4'd0; // phase taken from this comma
                    comma_cnt <= 3'd1;
                end
                CHECK: if (group_tick) begin
                    if (!comma_match)
                        state <= HUNT;
                    else if (comma_cnt == 3'(SYNC_COMMAS - 1))
                        state <= LOCKED;
                    else
                        comma_cnt <= comma_cnt + 3'd1;
                end
                default: ; // stays locked until reset
            endcase
        end
    end

    rx_symbol_if sym ();

    rx_8b10b_decode i_decode (
        .BUS_CLK, .reset, .code_valid, .code(window), .sym(sym), .err_cnt(decoder_err_cnt)
    );

    rx_frame_builder i_framer (
        .BUS_CLK, .reset, .sym(sym), .push, .push_data, .full, .lost_cnt(lost_err_cnt)
    );

    rx_sync_fifo i_fifo (
        .BUS_CLK, .reset, .push, .push_data, .pop(read), .pop_data(data),
        .full, .empty, .size(fifo_size)
    );

endmodule

/* design/bus_to_ip.sv */
// maps the system bus window BASEADDR..HIGHADDR onto the local register bus
`timescale 1ns/1ps

module bus_to_ip #(
    parameter logic [fei4_rx_reg_pkg::ABUSWIDTH-1:0] BASEADDR = 16'h0000,
    parameter logic [fei4_rx_reg_pkg::ABUSWIDTH-1:0] HIGHADDR = 16'h000F
) (
    input  logic                                    BUS_CLK,
    input  logic [fei4_rx_reg_pkg::ABUSWIDTH-1:0]   BUS_ADD,
    input  logic [7:0]                              BUS_DATA_IN,
    input  logic                                    BUS_WR,
    input  logic                                    BUS_RD,
    output logic [7:0]                              BUS_DATA_OUT,
    ip_bus_if.master                                ip
);
    import fei4_rx_reg_pkg::*;

    logic                 in_window;
    logic [ABUSWIDTH-1:0] offset;
    logic                 rd_q;  // read strobe of the cycle the data belongs to

    assign in_window     = (BUS_ADD >= BASEADDR) && (BUS_ADD <= HIGHADDR);
    assign offset        = BUS_ADD - BASEADDR;
    assign ip.ip_add     = offset[IP_AW-1:0];
    assign ip.ip_data_in = BUS_DATA_IN;
    assign ip.ip_wr      = BUS_WR && in_window;
    assign ip.ip_rd      = BUS_RD && in_window;

    always_ff @(posedge BUS_CLK) begin
        rd_q <= ip.ip_rd;
    end

    assign BUS_DATA_OUT = rd_q ? ip.ip_data_out : 8'h00; // other slaves share the bus

endmodule

/* design/fei4_rx_core.sv */
// register file, reset pulses and FIFO word formatting around the receiver chain
// addresses 0 and 1 reset on write, 2 is status/config, 3 to 6 read back levels and counters
`timescale 1ns/1ps

module fei4_rx_core #(
    parameter logic [7:0] DATA_IDENTIFIER = 8'h00
) (
    input  logic        BUS_CLK,
    input  logic        RST,
    ip_bus_if.slave     ip,
    input  logic        RX_DATA,
    output logic        RX_READY,
    output logic        RX_8B10B_DECODER_ERR,
    output logic        RX_FIFO_OVERFLOW_ERR,
    output logic        RX_FIFO_FULL,
    input  logic        FIFO_READ,
    output logic        FIFO_EMPTY,
    output logic [31:0] FIFO_DATA
);
    import fei4_rx_reg_pkg::*;

    // bit 0 soft reset, bit 1 receiver reset
    logic [1:0]  rst_req;
    logic [1:0]  rst_ff1;
    logic [1:0]  rst_ff2;
    logic [1:0]  rst_pulse;
    logic        soft_rst;
    logic        rx_rst;
    logic [7:0]  status_reg;
    logic [23:0] fe_data;
    logic [15:0] fifo_size;
    logic [7:0]  size_hi_buf;  // taken when the low byte is read
    logic [7:0]  dec_err_cnt;
    logic [7:0]  dec_err_buf;
    logic [7:0]  lost_err_cnt;
    logic [7:0]  lost_err_buf;
    logic [7:0]  rd_data;

    assign rst_req[0] = ip.ip_wr && (ip.ip_add == REG_RESET);   // data ignored
    assign rst_req[1] = ip.ip_wr && (ip.ip_add == REG_RX_RESET);

    always_ff @(posedge BUS_CLK) begin
        if (RST) begin
            rst_ff1   <= '0;
            rst_ff2   <= '0;
            rst_pulse <= '0;
        end else begin
            rst_ff1   <= rst_req;
            rst_ff2   <= rst_ff1;
            rst_pulse <= rst_ff1 & ~rst_ff2; // one cycle per write burst
        end
    end

    assign soft_rst = RST | rst_pulse[0];
    assign rx_rst   = soft_rst | rst_pulse[1];

    always_ff @(posedge BUS_CLK) begin
        if (soft_rst)
            status_reg <= 8'h00;
        else if (ip.ip_wr && (ip.ip_add == REG_STATUS))
            status_reg <= ip.ip_data_in;
    end

    always_ff @(posedge BUS_CLK) begin
        if (ip.ip_rd && (ip.ip_add == REG_SIZE_LO))
            size_hi_buf <= fifo_size[15:8];
        dec_err_buf  <= dec_err_cnt;
        lost_err_buf <= lost_err_cnt;
    end

    // read data follows the address by one clock
    always_ff @(posedge BUS_CLK) begin
        case (ip.ip_add)
            REG_RESET:    rd_data <= VERSION;
            REG_STATUS:   rd_data <= {status_reg[7:1], RX_READY}; // bit 0 reads lock
            REG_SIZE_LO:  rd_data <= fifo_size[7:0];
            REG_SIZE_HI:  rd_data <= size_hi_buf;
            REG_DEC_ERR:  rd_data <= dec_err_buf;
            REG_LOST_ERR: rd_data <= lost_err_buf;
            default:      rd_data <= 8'h00;
        endcase
    end

    assign ip.ip_data_out = rd_data;

    assign RX_8B10B_DECODER_ERR = (dec_err_cnt != 8'h00);
    assign RX_FIFO_OVERFLOW_ERR = (lost_err_cnt != 8'h00);
    assign FIFO_DATA            = {DATA_IDENTIFIER, fe_data};

    receiver_logic i_receiver_logic (
        .BUS_CLK         (BUS_CLK),
        .reset           (rx_rst),
        .RX_DATA         (RX_DATA),
        .invert_rx_data  (status_reg[STATUS_INVERT_BIT]),
        .read            (FIFO_READ),
        .data            (fe_data),
        .empty           (FIFO_EMPTY),
        .full            (RX_FIFO_FULL),
        .rec_sync_ready  (RX_READY),
        .decoder_err_cnt (dec_err_cnt),
        .lost_err_cnt    (lost_err_cnt),
        .fifo_size       (fifo_size)
    );

endmodule

/* design/fei4_rx.sv */
// FE-I4 8b10b receiver top level with plain bus and FIFO ports
// instantiate with the register window and the identifier placed on each FIFO word
`timescale 1ns/1ps

module fei4_rx #(
    parameter logic [fei4_rx_reg_pkg::ABUSWIDTH-1:0] BASEADDR = 16'h0000,
    parameter logic [fei4_rx_reg_pkg::ABUSWIDTH-1:0] HIGHADDR = 16'h000F,
    parameter logic [7:0] DATA_IDENTIFIER = 8'h00
) (
    input  logic                                    BUS_CLK,
    input  logic                                    RST,
    input  logic [fei4_rx_reg_pkg::ABUSWIDTH-1:0]   BUS_ADD,
    input  logic [7:0]                              BUS_DATA_IN,
    output logic [7:0]                              BUS_DATA_OUT,
    input  logic                                    BUS_WR,
    input  logic                                    BUS_RD,
    input  logic                                    RX_DATA,
    output logic                                    RX_READY,
    output logic                                    RX_8B10B_DECODER_ERR,
    output logic                                    RX_FIFO_OVERFLOW_ERR,
    output logic                                    RX_FIFO_FULL,
    input  logic                                    FIFO_READ,
    output logic                                    FIFO_EMPTY,
    output logic [31:0]                             FIFO_DATA
);

    ip_bus_if ip ();

    bus_to_ip #(
        .BASEADDR(BASEADDR),
        .HIGHADDR(HIGHADDR)
    ) i_bus_to_ip (
        .BUS_CLK, .BUS_ADD, .BUS_DATA_IN, .BUS_WR, .BUS_RD, .BUS_DATA_OUT,
        .ip(ip)
    );

    fei4_rx_core #(
        .DATA_IDENTIFIER(DATA_IDENTIFIER)
    ) i_core (
        .BUS_CLK, .RST, .ip(ip), .RX_DATA, .RX_READY, .RX_8B10B_DECODER_ERR,
        .RX_FIFO_OVERFLOW_ERR, .RX_FIFO_FULL, .FIFO_READ, .FIFO_EMPTY, .FIFO_DATA
    );

endmodule

/* dv/fei4_rx_props.sv */
// concurrent checks on the receiver core counters, flags and FIFO state
// attached to fei4_rx_core with bind from the testbench
`timescale 1ns/1ps

module fei4_rx_props (
    input logic       BUS_CLK,
    input logic       RST,
    input logic       rx_rst,       // any reset of the receiver chain
    input logic [7:0] dec_err_cnt,
    input logic [7:0] lost_err_cnt,
    input logic       dec_err_flag,
    input logic       lost_err_flag,
    input logic       fifo_full,
    input logic       fifo_empty,
    input logic       rx_ready
);

    flags_hold: assert property (@(posedge BUS_CLK)
        ($fell(dec_err_flag) || $fell(lost_err_flag)) |-> $past(rx_rst))
        else $error("error flag dropped without a reset");

    counters_rise: assert property (@(posedge BUS_CLK)
        ((dec_err_cnt < $past(dec_err_cnt)) || (lost_err_cnt < $past(lost_err_cnt)))
        |-> $past(rx_rst))
        else $error("error counter decreased without a reset");

    // counts are undefined before the first reset edge
    fifo_state: assert property (@(posedge BUS_CLK) disable iff (RST)
        !(fifo_empty && fifo_full))
        else $error("FIFO reports empty and full together");

    ready_cleared: assert property (@(posedge BUS_CLK) rx_rst |=> !rx_ready)
        else $error("receiver still locked after a reset pulse");

endmodule

/* dv/fei4_rx_tb.sv */
// testbench for the FE-I4 receiver with a serial link model, register bus and FIFO readout
// drives comma idles and frames into the link and checks registers, flags and FIFO words
`timescale 1ns/1ps

module fei4_rx_tb;
    import fei4_rx_reg_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int GROUP_BITS   = 10;
    localparam int FRAME_CYCLES = 6 * GROUP_BITS;  // SOF, 3 bytes, EOF, one spare group
    localparam int READY_LIMIT  = 200;
    localparam int FRAMES_RUN   = 29;               // all frames of all tests
    localparam int FIFO_WORDS   = 16;
    localparam int WATCHDOG_CYCLES = FRAMES_RUN * FRAME_CYCLES + 6 * READY_LIMIT + 3000;
    localparam logic [15:0] BASE       = 16'h1000;
    localparam logic [15:0] A_VERSION  = BASE + 16'(REG_RESET);
    localparam logic [15:0] A_RX_RESET = BASE + 16'(REG_RX_RESET);
    localparam logic [15:0] A_STATUS   = BASE + 16'(REG_STATUS);
    localparam logic [15:0] A_SIZE_LO  = BASE + 16'(REG_SIZE_LO);
    localparam logic [15:0] A_SIZE_HI  = BASE + 16'(REG_SIZE_HI);
    localparam logic [15:0] A_DEC_ERR  = BASE + 16'(REG_DEC_ERR);
    localparam logic [15:0] A_LOST_ERR = BASE + 16'(REG_LOST_ERR);
    // RD- code groups with bit a in bit 9
    localparam logic [9:0] K28_5 = 10'b0011111010;
    localparam logic [9:0] K28_7 = 10'b0011111000;
    localparam logic [9:0] K28_3 = 10'b0011110011;
    localparam logic [9:0] BAD_GROUP = 10'b0000000000;
    localparam logic [5:0] SIX_RDN [32] = '{
        6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
        6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
        6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
        6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
    };
    localparam logic [3:0] FOUR_RDN [8] = '{
        4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
    };

    logic        BUS_CLK = 1'b0;
    logic        RST;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic [7:0]  bus_data_out;
    logic        bus_wr;
    logic        bus_rd;
    logic        rx_data = 1'b0;
    logic        rx_ready;
    logic        dec_err;
    logic        overflow_err;
    logic        fifo_full;
    logic        fifo_read;
    logic        fifo_empty;
    logic [31:0] fifo_data;
    logic [9:0]  tx_q [$];      // code groups waiting for the line
    logic [9:0]  tx_cur;
    int          tx_bit = 0;
    logic        line_inv = 1'b0;
    logic [23:0] model [$];     // words expected in the FIFO
    int          exp_lost = 0;
    int          value_errs = 0;
    int          other_errs = 0;
    string       test_name = "reset";

    fei4_rx #(
        .BASEADDR(16'h1000),
        .HIGHADDR(16'h100F),
        .DATA_IDENTIFIER(8'hA5)
    ) uut (
        .BUS_CLK(BUS_CLK), .RST(RST), .BUS_ADD(bus_add), .BUS_DATA_IN(bus_data_in),
        .BUS_DATA_OUT(bus_data_out), .BUS_WR(bus_wr), .BUS_RD(bus_rd), .RX_DATA(rx_data),
        .RX_READY(rx_ready), .RX_8B10B_DECODER_ERR(dec_err),
        .RX_FIFO_OVERFLOW_ERR(overflow_err), .RX_FIFO_FULL(fifo_full),
        .FIFO_READ(fifo_read), .FIFO_EMPTY(fifo_empty), .FIFO_DATA(fifo_data)
    );

    bind fei4_rx_core fei4_rx_props i_props (
        .BUS_CLK(BUS_CLK), .RST(RST), .rx_rst(rx_rst), .dec_err_cnt(dec_err_cnt),
        .lost_err_cnt(lost_err_cnt), .dec_err_flag(RX_8B10B_DECODER_ERR),
        .lost_err_flag(RX_FIFO_OVERFLOW_ERR), .fifo_full(RX_FIFO_FULL),
        .fifo_empty(FIFO_EMPTY), .rx_ready(RX_READY)
    );

    always #(CLK_PERIOD / 2) BUS_CLK = ~BUS_CLK;

    // line model sends commas whenever nothing is queued
    always @(negedge BUS_CLK) begin
        if (tx_bit == 0) begin
            if (tx_q.size() != 0)
                tx_cur = tx_q.pop_front();
            else
                tx_cur = K28_5;
        end
        rx_data = tx_cur[GROUP_BITS - 1 - tx_bit] ^ line_inv;
        tx_bit  = (tx_bit == GROUP_BITS - 1) ? 0 : tx_bit + 1;
    end

    function automatic logic [9:0] encode_byte(input logic [7:0] b);
        return {SIX_RDN[b[4:0]], FOUR_RDN[b[7:5]]};
    endfunction

    task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp)
        else begin
            value_errs++;
            $display("Fail %s %s: expected %0h, actual %0h", test_name, what, exp, got);
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond)
        else begin
            other_errs++;
            $display("%s: %s", test_name, msg);
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(negedge BUS_CLK);
        bus_add     = addr;
        bus_data_in = data;
        bus_wr      = 1'b1;
        @(negedge BUS_CLK);
        bus_wr = 1'b0;
    endtask

    task automatic bus_read_check(input logic [15:0] addr, input logic [7:0] exp,
                                  input string what);
        @(negedge BUS_CLK);
        bus_add = addr;
        bus_rd  = 1'b1;
        @(negedge BUS_CLK);     // data follows the address by one clock
        check_value(what, 32'(exp), 32'(bus_data_out));
        bus_rd = 1'b0;
    endtask

    // pulse lands on the second edge after the write edge
    task automatic pulse_reset(input logic [15:0] addr);
        bus_write(addr, 8'h00);
        repeat (2) @(posedge BUS_CLK);
        @(negedge BUS_CLK);
        check_true(!rx_ready, "RX_READY still high after the reset pulse");
    endtask

    task automatic wait_ready();
        int n;
        n = 0;
        while (!rx_ready && n < READY_LIMIT) begin
            @(negedge BUS_CLK);
            n++;
        end
        check_true(rx_ready, "receiver did not lock on comma idles");
    endtask

    task automatic send_frame(input logic [23:0] word, input logic corrupt);
        @(posedge BUS_CLK);
        tx_q.push_back(K28_7);
        tx_q.push_back(encode_byte(word[23:16]));
        if (corrupt)
            tx_q.push_back(BAD_GROUP);
        tx_q.push_back(encode_byte(word[15:8]));
        tx_q.push_back(encode_byte(word[7:0]));
        tx_q.push_back(K28_3);
    endtask

    task automatic send_random_frames(input int n);
        logic [23:0] word;
        for (int i = 0; i < n; i++) begin
            word = 24'($urandom);
            send_frame(word, 1'b0);
            if (model.size() < FIFO_WORDS)
                model.push_back(word);
            else
                exp_lost++;     // word dropped by a full FIFO
        end
    endtask

    // waits for the queue, the last group and the decoder, framer and FIFO stages
    task automatic flush_link();
        while (tx_q.size() != 0)
            @(posedge BUS_CLK);
        repeat (2 * GROUP_BITS + 4) @(posedge BUS_CLK);
        @(negedge BUS_CLK);
    endtask

    task automatic pop_check();
        logic [31:0] exp;
        @(negedge BUS_CLK);
        check_true(!fifo_empty, "FIFO empty while a word is expected");
        exp = {8'hA5, model.pop_front()};
        check_value("fifo word", exp, fifo_data);
        fifo_read = 1'b1;
        @(negedge BUS_CLK);
        fifo_read = 1'b0;
    endtask

    task automatic check_size();
        bus_read_check(A_SIZE_LO, 8'(model.size()), "size low byte");
        bus_read_check(A_SIZE_HI, 8'h00, "size high byte");
    endtask

    initial begin
        void'($urandom(85641));
        RST         = 1'b1;
        bus_add     = '0;
        bus_data_in = '0;
        bus_wr      = 1'b0;
        bus_rd      = 1'b0;
        fifo_read   = 1'b0;
        repeat (8) @(posedge BUS_CLK);
        @(negedge BUS_CLK);
        RST = 1'b0;
        check_true(!rx_ready && fifo_empty && !fifo_full && !dec_err && !overflow_err,
                   "wrong state after reset");

        test_name = "sync";
        wait_ready();
        bus_read_check(A_STATUS, 8'h01, "status lock bit");
        pulse_reset(A_VERSION);
        bus_read_check(A_STATUS, 8'h00, "status after soft reset");
        wait_ready();

        test_name = "registers";
        bus_read_check(A_VERSION, 8'h02, "version");
        bus_write(A_STATUS, 8'hF4);
        bus_read_check(A_STATUS, 8'hF5, "status readback");
        bus_write(16'h1010, 8'h00);     // offset 0 lies outside the window
        bus_write(16'h1012, 8'h00);
        bus_write(16'h0FFF, 8'hFF);
        bus_read_check(A_STATUS, 8'hF5, "status after outside writes");
        bus_read_check(16'h1010, 8'h00, "read outside window");

        test_name = "frames";
        send_random_frames(5);
        flush_link();
        check_size();
        pop_check();
        pop_check();
        check_size();
        while (model.size() > 0)
            pop_check();
        check_true(fifo_empty, "FIFO not empty after all words were read");

        test_name = "invert";
        bus_write(A_STATUS, 8'hF6);
        @(posedge BUS_CLK);
        line_inv = 1'b1;
        repeat (3 * GROUP_BITS) @(posedge BUS_CLK);
        pulse_reset(A_RX_RESET);        // relock on the inverted line
        wait_ready();
        bus_read_check(A_STATUS, 8'hF7, "status with invert");
        send_random_frames(3);
        flush_link();
        check_size();
        while (model.size() > 0)
            pop_check();

        test_name = "decode_error";
        bus_read_check(A_DEC_ERR, 8'h00, "decoder count before");
        send_frame(24'($urandom), 1'b1);
        flush_link();
        check_true(dec_err, "decoder error flag not raised");
        bus_read_check(A_DEC_ERR, 8'h01, "decoder count after one");
        @(posedge BUS_CLK);
        tx_q.push_back(BAD_GROUP);
        flush_link();
        bus_read_check(A_DEC_ERR, 8'h02, "decoder count after two");
        check_true(fifo_empty, "frame with a bad code group was stored");

        test_name = "overflow";
        send_random_frames(20);
        flush_link();
        check_true(fifo_full, "RX_FIFO_FULL low with 20 words sent");
        check_true(overflow_err, "overflow flag not raised");
        check_size();
        bus_read_check(A_LOST_ERR, 8'(exp_lost), "lost count");
        pop_check();

        test_name = "rx_reset";
        pulse_reset(A_RX_RESET);
        model.delete();
        exp_lost = 0;
        check_true(fifo_empty && !fifo_full, "FIFO not emptied by receiver reset");
        check_true(!dec_err && !overflow_err, "error flags kept after receiver reset");
        wait_ready();
        check_size();
        bus_read_check(A_DEC_ERR, 8'h00, "decoder count cleared");
        bus_read_check(A_LOST_ERR, 8'h00, "lost count cleared");
        bus_read_check(A_STATUS, 8'hF7, "status kept");

        $display("value errors: %0d, other errors: %0d", value_errs, other_errs);
        if (value_errs + other_errs == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired in test %s", test_name);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

/* fei4_rx.f */
design/fei4_rx_reg_pkg.sv
design/fei4_rx_link_pkg.sv
design/fei4_rx_ifs.sv
design/rx_sync_fifo.sv
design/rx_8b10b_decode.sv
design/rx_frame_builder.sv
design/receiver_logic.sv
design/bus_to_ip.sv
design/fei4_rx_core.sv
design/fei4_rx.sv
dv/fei4_rx_props.sv
dv/fei4_rx_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the FE-I4 receiver testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module fei4_rx_tb \
    -f fei4_rx.f -Mdir obj_dir -o fei4_rx_sim
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/fei4_rx_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation PASSED$" sim.log; then
    exit 0
fi
exit 1
